//--- all.f
+incdir+hw
hw/afu_region_pkg.sv
hw/afu_null_port.sv
hw/afu_lb_port.sv
hw/afu_req_decode.sv
hw/afu_port_execute.sv
hw/afu_rsp_result.sv
hw/afu_region_top.sv
verif/tb_afu_region.sv

//--- hw/afu_lb_port.sv
// Loopback endpoint with a four-word read/write buffer
// and a wrapping count of accepted writes

`timescale 1ns/1ns
`include "afu_region_macros.svh"

module afu_lb_port (
   input  logic                   i_clk,
   input  logic                   i_arst_n,
   input  logic                   i_wr,
   input  logic [`AFU_ADDR_W-1:0] i_addr,
   input  logic [`AFU_DATA_W-1:0] i_wdata,
   output logic [`AFU_DATA_W-1:0] o_rdata
);

   localparam int IDX_W = $clog2(`AFU_LB_DEPTH);

   logic [`AFU_DATA_W-1:0]  buf_q [`AFU_LB_DEPTH];
   logic [`AFU_LB_CNT_W-1:0] wr_cnt;
   logic                     in_buf;

   assign in_buf = (i_addr < `AFU_ADDR_W'(`AFU_LB_DEPTH));

   // ----------------------------------------
   // Buffer and write counter
   // ----------------------------------------
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < `AFU_LB_DEPTH; i++) begin
            buf_q[i] <= '0;
         end
         wr_cnt <= '0;
      end else if (i_wr) begin
         // Every accepted write counts, whatever its address
         wr_cnt <= wr_cnt + 1'b1;
         if (in_buf) begin
            buf_q[i_addr[IDX_W-1:0]] <= i_wdata;
         end
      end
   end

   // Read mux
   always_comb begin
      if (in_buf)
         o_rdata = buf_q[i_addr[IDX_W-1:0]];
      else if (i_addr == `AFU_LB_CNT_ADDR)
         o_rdata = {{(`AFU_DATA_W-`AFU_LB_CNT_W){1'b0}}, wr_cnt};
      else
         o_rdata = '0;
   end

   // Counter moves only on a fresh one-cycle write routed here by execute
   a_cnt_on_wr: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      $changed(wr_cnt) |-> ($past(i_wr) && !$past(i_wr, 2)));

endmodule

//--- hw/afu_null_port.sv
// Null endpoint with a read-only feature header and one scratch register

`timescale 1ns/1ns
`include "afu_region_macros.svh"

module afu_null_port #(
   parameter int unsigned PORT_PID = 0
) (
   input  logic                   i_clk,
   input  logic                   i_arst_n,
   input  logic                   i_wr,
   input  logic [`AFU_ADDR_W-1:0] i_addr,
   input  logic [`AFU_DATA_W-1:0] i_wdata,
   output logic [`AFU_DATA_W-1:0] o_rdata
);

   // Feature header carries the PID above the base feature ID
   localparam logic [`AFU_DATA_W-1:0] HEADER = {
      {(`AFU_DATA_W-16){1'b0}},
      4'(PORT_PID),
      `AFU_FEAT_ID
   };

   logic [`AFU_DATA_W-1:0] scratch;

   // ----------------------------------------
   // Scratch register
   // ----------------------------------------
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         scratch <= '0;
      end else if (i_wr && i_addr == `AFU_SCRATCH_ADDR) begin
         scratch <= i_wdata;
      end
   end

   // ----------------------------------------
   // Read mux
   // ----------------------------------------
   // Writes to the header address fall through and are dropped
   always_comb begin
      case (i_addr)
         `AFU_DFH_ADDR:     o_rdata = HEADER;
         `AFU_SCRATCH_ADDR: o_rdata = scratch;
         default:           o_rdata = '0;
      endcase
   end

endmodule

//--- hw/afu_port_execute.sv
// Endpoint array, one per port ID, with the loopback at its own PID
// Routes writes to the addressed endpoint and registers its read data

`timescale 1ns/1ns
`include "afu_region_macros.svh"

module afu_port_execute import afu_region_pkg::*; (
   input  logic                   i_clk,
   input  logic                   i_arst_n,
   input  logic                   i_valid,
   input  logic [`AFU_PID_W-1:0]  i_pid,
   input  afu_op_e                i_op,
   input  logic [`AFU_ADDR_W-1:0] i_addr,
   input  logic [`AFU_DATA_W-1:0] i_wdata,
   input  afu_status_e            i_status,
   output logic                   o_valid,
   output logic [`AFU_DATA_W-1:0] o_rdata
);

   logic                   wr_ok;
   logic                   rd_ok;
   logic [`AFU_NUM_PORTS-1:0] port_wr;
   logic [`AFU_DATA_W-1:0] port_rdata [`AFU_NUM_PORTS];
   logic [`AFU_DATA_W-1:0] rd_sel;

   // Failed checks never reach an endpoint
   assign wr_ok = i_valid && (i_op == OP_WRITE) && (i_status == RSP_OK);
   assign rd_ok = (i_op == OP_READ) && (i_status == RSP_OK);

   // ----------------------------------------
   // Endpoints
   // ----------------------------------------
   for (genvar p = 0; p < `AFU_NUM_PORTS; p++) begin : gen_port
      assign port_wr[p] = wr_ok && (i_pid == `AFU_PID_W'(p));

      if (p == `AFU_LB_PID) begin : gen_lb
         afu_lb_port u_lb (
            .i_clk    (i_clk),
            .i_arst_n (i_arst_n),
            .i_wr     (port_wr[p]),
            .i_addr   (i_addr),
            .i_wdata  (i_wdata),
            .o_rdata  (port_rdata[p])
         );
      end else begin : gen_null
         afu_null_port #(
            .PORT_PID (p)
         ) u_null (
            .i_clk    (i_clk),
            .i_arst_n (i_arst_n),
            .i_wr     (port_wr[p]),
            .i_addr   (i_addr),
            .i_wdata  (i_wdata),
            .o_rdata  (port_rdata[p])
         );
      end
   end

   always_comb begin
      rd_sel = '0;
      for (int p = 0; p < `AFU_NUM_PORTS; p++) begin
         if (i_pid == `AFU_PID_W'(p)) rd_sel = port_rdata[p];
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) o_valid <= 1'b0;
      else           o_valid <= i_valid;
   end

   // Writes and rejected requests return zero data
   always_ff @(posedge i_clk) begin
      if (i_valid) o_rdata <= rd_ok ? rd_sel : '0;
   end

endmodule

//--- hw/afu_region_macros.svh
// Sizes, CSR address map and feature constants for the accelerator port region

`ifndef AFU_REGION_MACROS_SVH
`define AFU_REGION_MACROS_SVH

// Region sizes
`define AFU_NUM_PORTS     5
`define AFU_PID_W         3
`define AFU_ADDR_W        4
`define AFU_DATA_W        64

// Port that holds the loopback endpoint
`define AFU_LB_PID        1
`define AFU_LB_DEPTH      4
`define AFU_LB_CNT_W      16
`define AFU_LB_CNT_ADDR   4'h4

// Null endpoint CSR map
`define AFU_FEAT_ID       12'h014
`define AFU_DFH_ADDR      4'h0
`define AFU_SCRATCH_ADDR  4'h1

`endif

//--- hw/afu_region_pkg.sv
// Opcode, response status and handshake state types shared by the port region

package afu_region_pkg;

   // ----------------------------------------
   // Request opcodes
   // ----------------------------------------
   // Codes 2 and 3 are reserved and answered with RSP_BAD_OP
   typedef enum logic [1:0] {
      OP_READ  = 2'd0,
      OP_WRITE = 2'd1
   } afu_op_e;

   // ----------------------------------------
   // Response status
   // ----------------------------------------
   typedef enum logic [1:0] {
      RSP_OK      = 2'd0,
      RSP_BAD_PID = 2'd1,
      RSP_BAD_OP  = 2'd2
   } afu_status_e;

   // ----------------------------------------
   // Four-phase handshake states
   // ----------------------------------------
   // Decode walks IDLE and BUSY, result walks IDLE, ACK and WAIT_DROP
   typedef enum logic [1:0] {
      HS_IDLE      = 2'd0,
      HS_BUSY      = 2'd1,
      HS_ACK       = 2'd2,
      HS_WAIT_DROP = 2'd3
   } afu_hs_state_e;

endpackage

//--- hw/afu_region_top.sv
// Port region top level
// Request decode, endpoint execute and response result in a chain

`timescale 1ns/1ns
`include "afu_region_macros.svh"

module afu_region_top import afu_region_pkg::*; (
   input  logic                   i_clk,
   input  logic                   i_arst_n,
   input  logic                   i_req,
   input  logic [`AFU_PID_W-1:0]  i_req_pid,
   input  logic [1:0]             i_req_op,
   input  logic [`AFU_ADDR_W-1:0] i_req_addr,
   input  logic [`AFU_DATA_W-1:0] i_req_wdata,
   output logic                   o_ack,
   output logic [`AFU_DATA_W-1:0] o_rsp_rdata,
   output afu_status_e            o_rsp_status
);

   logic                   dec_valid;
   logic [`AFU_PID_W-1:0]  dec_pid;
   afu_op_e                dec_op;
   logic [`AFU_ADDR_W-1:0] dec_addr;
   logic [`AFU_DATA_W-1:0] dec_wdata;
   afu_status_e            dec_status;
   logic                   exe_valid;
   logic [`AFU_DATA_W-1:0] exe_rdata;
   logic                   rsp_done;

   afu_req_decode u_decode (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_req       (i_req),
      .i_req_pid   (i_req_pid),
      .i_req_op    (i_req_op),
      .i_req_addr  (i_req_addr),
      .i_req_wdata (i_req_wdata),
      .i_done      (rsp_done),
      .o_valid     (dec_valid),
      .o_pid       (dec_pid),
      .o_op        (dec_op),
      .o_addr      (dec_addr),
      .o_wdata     (dec_wdata),
      .o_status    (dec_status),
      .o_busy      ()
   );

   afu_port_execute u_execute (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_valid  (dec_valid),
      .i_pid    (dec_pid),
      .i_op     (dec_op),
      .i_addr   (dec_addr),
      .i_wdata  (dec_wdata),
      .i_status (dec_status),
      .o_valid  (exe_valid),
      .o_rdata  (exe_rdata)
   );

   // Status is still held by decode when execute answers
   afu_rsp_result u_result (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_valid  (exe_valid),
      .i_rdata  (exe_rdata),
      .i_status (dec_status),
      .i_req    (i_req),
      .o_ack    (o_ack),
      .o_rdata  (o_rsp_rdata),
      .o_status (o_rsp_status),
      .o_done   (rsp_done)
   );

endmodule

//--- hw/afu_req_decode.sv
// Request capture for the four-phase host handshake
// Checks the port ID and opcode and issues one decoded request pulse

`timescale 1ns/1ns
`include "afu_region_macros.svh"

module afu_req_decode import afu_region_pkg::*; (
   input  logic                   i_clk,
   input  logic                   i_arst_n,
   input  logic                   i_req,
   input  logic [`AFU_PID_W-1:0]  i_req_pid,
   input  logic [1:0]             i_req_op,
   input  logic [`AFU_ADDR_W-1:0] i_req_addr,
   input  logic [`AFU_DATA_W-1:0] i_req_wdata,
   input  logic                   i_done,
   output logic                   o_valid,
   output logic [`AFU_PID_W-1:0]  o_pid,
   output afu_op_e                o_op,
   output logic [`AFU_ADDR_W-1:0] o_addr,
   output logic [`AFU_DATA_W-1:0] o_wdata,
   output afu_status_e            o_status,
   output logic                   o_busy
);

   afu_hs_state_e state;
   logic          take;

   // New request is accepted only while no other one is in flight
   assign take   = (state == HS_IDLE) && i_req;
   assign o_busy = (state != HS_IDLE);

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state   <= HS_IDLE;
         o_valid <= 1'b0;
      end else begin
         o_valid <= take;
         case (state)
            HS_IDLE: if (i_req) state <= HS_BUSY;
            HS_BUSY: if (i_done) state <= HS_IDLE;
            default: state <= HS_IDLE;
         endcase
      end
   end

   // Request fields and the check result stay put until the handshake ends
   always_ff @(posedge i_clk) begin
      if (take) begin
         o_pid   <= i_req_pid;
         o_op    <= afu_op_e'(i_req_op);
         o_addr  <= i_req_addr;
         o_wdata <= i_req_wdata;
         if (i_req_pid >= `AFU_PID_W'(`AFU_NUM_PORTS))
            o_status <= RSP_BAD_PID;
         else if (i_req_op > 2'd1)
            o_status <= RSP_BAD_OP;
         else
            o_status <= RSP_OK;
      end
   end

   // Host must hold the captured request while it keeps i_req high
   a_req_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (o_busy && i_req) |-> (i_req_pid == o_pid && i_req_op == o_op &&
                             i_req_addr == o_addr && i_req_wdata == o_wdata));

endmodule

//--- hw/afu_rsp_result.sv
// Response register and four-phase acknowledge toward the host

`timescale 1ns/1ns
`include "afu_region_macros.svh"

module afu_rsp_result import afu_region_pkg::*; (
   input  logic                   i_clk,
   input  logic                   i_arst_n,
   input  logic                   i_valid,
   input  logic [`AFU_DATA_W-1:0] i_rdata,
   input  afu_status_e            i_status,
   input  logic                   i_req,
   output logic                   o_ack,
   output logic [`AFU_DATA_W-1:0] o_rdata,
   output afu_status_e            o_status,
   output logic                   o_done
);

   afu_hs_state_e state;

   // Handshake closes on the edge where the host is seen low
   assign o_done = o_ack && !i_req;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= HS_IDLE;
         o_ack <= 1'b0;
      end else begin
         case (state)
            HS_IDLE: begin
               if (i_valid) begin
                  state <= HS_ACK;
                  o_ack <= 1'b1;
               end
            end
            // Host still holding i_req past the first ack cycle
            HS_ACK, HS_WAIT_DROP: begin
               if (!i_req) begin
                  state <= HS_IDLE;
                  o_ack <= 1'b0;
               end else begin
                  state <= HS_WAIT_DROP;
               end
            end
            default: begin
               state <= HS_IDLE;
               o_ack <= 1'b0;
            end
         endcase
      end
   end

   // Response stays valid for the whole time o_ack is high
   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         o_rdata  <= i_rdata;
         o_status <= i_status;
      end
   end

   // Ack falls only after the host dropped i_req, with no new request overlapping it
   a_ack_fall: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      $fell(o_ack) |-> ($past(!i_req) && !i_req));

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the port region testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_afu_region -o tb_afu_region

status=0
./obj_dir/tb_afu_region > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q '>>> FAIL' sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"

//--- verif/tb_afu_region.sv
// Directed testbench for the port region
// Four-phase host driver, compare tasks, handshake monitor and watchdog

`timescale 1ns/1ns
`include "afu_region_macros.svh"

module tb_afu_region import afu_region_pkg::*; ();

   localparam int RESET_CYCLES = 8;
   localparam int NUM_REQS     = 40;
   localparam int ACK_LIMIT    = 16;

   logic                   i_clk = 1'b0;
   logic                   i_arst_n;
   logic                   i_req;
   logic [`AFU_PID_W-1:0]  i_req_pid;
   logic [1:0]             i_req_op;
   logic [`AFU_ADDR_W-1:0] i_req_addr;
   logic [`AFU_DATA_W-1:0] i_req_wdata;
   logic                   o_ack;
   logic [`AFU_DATA_W-1:0] o_rsp_rdata;
   afu_status_e            o_rsp_status;

   logic [63:0]            rng = 64'd88;
   int                     errors = 0;
   int                     tests = 0;
   int                     failed_tests = 0;
   int                     test_err0 = 0;
   string                  test_name = "none";
   logic                   prev_req = 1'b0;
   logic                   prev_ack = 1'b0;
   // Expected register contents, kept from the writes the tests send
   logic [`AFU_DATA_W-1:0] scratch_model [`AFU_NUM_PORTS];
   logic [`AFU_DATA_W-1:0] lb_model [4];
   int                     lb_writes = 0;

   afu_region_top i_dut (.*);

   always #2 i_clk = ~i_clk;

   // Hard limit on run time, scaled to the number of requests
   initial begin
      #((RESET_CYCLES + NUM_REQS * 20) * 4);
      $display("Watchdog: run did not finish within %0d requests of 20 cycles", NUM_REQS);
      $display(">>> FAIL");
      $finish;
   end

   // xorshift64
   function automatic logic [63:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 7);
      rng = rng ^ (rng << 17);
      return rng;
   endfunction

   // Null endpoint header, PID in bits 15:12 above the base feature ID
   function automatic logic [`AFU_DATA_W-1:0] header_of(input int pid);
      return {48'd0, 4'(pid), `AFU_FEAT_ID};
   endfunction

   // ----------------------------------------
   // Handshake monitor
   // ----------------------------------------
   always @(negedge i_clk) begin
      if (i_arst_n === 1'b1) begin
         if (o_ack && !prev_ack && !i_req) begin
            errors++;
            $display("%s: o_ack rose while i_req was low", test_name);
         end
         if (!o_ack && prev_ack && prev_req) begin
            errors++;
            $display("%s: o_ack fell before i_req was dropped", test_name);
         end
      end
      prev_req <= i_req;
      prev_ack <= o_ack;
   end

   task automatic check_data(input string what, input logic [`AFU_DATA_W-1:0] exp,
                             input logic [`AFU_DATA_W-1:0] act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_status(input string what, input afu_status_e exp,
                               input afu_status_e act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s %s: expected %s, actual %s", test_name, what,
                  exp.name(), act.name());
      end
   endtask

   // One full four-phase request, i_req held for hold extra cycles after o_ack
   task automatic do_req(input int pid, input int op, input int addr,
                         input logic [`AFU_DATA_W-1:0] wdata, input int hold,
                         output logic [`AFU_DATA_W-1:0] rdata, output afu_status_e status);
      int n;
      @(posedge i_clk);
      i_req       <= 1'b1;
      i_req_pid   <= `AFU_PID_W'(pid);
      i_req_op    <= 2'(op);
      i_req_addr  <= `AFU_ADDR_W'(addr);
      i_req_wdata <= wdata;
      n = 0;
      do begin
         @(negedge i_clk);
         n++;
      end while (!o_ack && n < ACK_LIMIT);
      if (!o_ack) begin
         errors++;
         $display("%s: no acknowledge within %0d cycles of the request", test_name, ACK_LIMIT);
      end
      rdata  = o_rsp_rdata;
      status = o_rsp_status;
      for (int i = 0; i < hold; i++) begin
         @(negedge i_clk);
         if (!o_ack || o_rsp_rdata !== rdata || o_rsp_status !== status) begin
            errors++;
            $display("%s: response or acknowledge changed while i_req was held", test_name);
         end
      end
      @(posedge i_clk);
      i_req <= 1'b0;
      n = 0;
      do begin
         @(negedge i_clk);
         n++;
      end while (o_ack && n < ACK_LIMIT);
      if (o_ack) begin
         errors++;
         $display("%s: o_ack stayed high after i_req was dropped", test_name);
      end
   endtask

   task automatic read_and_check(input int pid, input int addr,
                                 input logic [`AFU_DATA_W-1:0] exp);
      logic [`AFU_DATA_W-1:0] d;
      afu_status_e            st;
      do_req(pid, 0, addr, '0, 0, d, st);
      check_status($sformatf("read pid %0d addr %0d", pid, addr), RSP_OK, st);
      check_data($sformatf("read pid %0d addr %0d", pid, addr), exp, d);
   endtask

   task automatic write_and_check(input int pid, input int addr,
                                  input logic [`AFU_DATA_W-1:0] wdata);
      logic [`AFU_DATA_W-1:0] d;
      afu_status_e            st;
      do_req(pid, 1, addr, wdata, 0, d, st);
      check_status($sformatf("write pid %0d addr %0d", pid, addr), RSP_OK, st);
      check_data($sformatf("write pid %0d addr %0d", pid, addr), '0, d);
   endtask

   // Rejected requests answer with zero data
   task automatic bad_req(input int pid, input int op, input int addr, input afu_status_e exp);
      logic [`AFU_DATA_W-1:0] d;
      afu_status_e            st;
      do_req(pid, op, addr, next_rand(), 0, d, st);
      check_status($sformatf("pid %0d op %0d", pid, op), exp, st);
      check_data($sformatf("pid %0d op %0d", pid, op), '0, d);
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_err0 = errors;
      tests++;
   endtask

   task automatic end_test();
      if (errors == test_err0) begin
         $display("%s: passed", test_name);
      end else begin
         failed_tests++;
         $display("%s: failed with %0d errors", test_name, errors - test_err0);
      end
   endtask

   // ----------------------------------------
   // Tests
   // ----------------------------------------
   task automatic read_headers();
      begin_test("read_headers");
      for (int p = 0; p < `AFU_NUM_PORTS; p++) begin
         if (p != `AFU_LB_PID) read_and_check(p, 0, header_of(p));
      end
      end_test();
   endtask

   task automatic scratch_rw();
      logic [`AFU_DATA_W-1:0] d;
      begin_test("scratch_rw");
      for (int p = 0; p < `AFU_NUM_PORTS; p++) begin
         if (p != `AFU_LB_PID) begin
            d = next_rand();
            write_and_check(p, 1, d);
            scratch_model[p] = d;
            read_and_check(p, 1, d);
            // Header is read-only
            write_and_check(p, 0, next_rand());
            read_and_check(p, 0, header_of(p));
         end
      end
      end_test();
   endtask

   task automatic loopback_rw();
      begin_test("loopback_rw");
      for (int i = 0; i < 4; i++) begin
         lb_model[i] = next_rand();
         write_and_check(`AFU_LB_PID, i, lb_model[i]);
         lb_writes++;
      end
      // Outside the buffer the write is dropped but still counted
      write_and_check(`AFU_LB_PID, 6, next_rand());
      lb_writes++;
      for (int i = 0; i < 4; i++) read_and_check(`AFU_LB_PID, i, lb_model[i]);
      read_and_check(`AFU_LB_PID, 6, '0);
      read_and_check(`AFU_LB_PID, 4, 64'(lb_writes));
      end_test();
   endtask

   task automatic illegal_requests();
      begin_test("illegal_requests");
      bad_req(5, 1, 1, RSP_BAD_PID);
      bad_req(7, 0, 0, RSP_BAD_PID);
      bad_req(`AFU_LB_PID, 2, 0, RSP_BAD_OP);
      bad_req(2, 3, 1, RSP_BAD_OP);
      read_and_check(`AFU_LB_PID, 0, lb_model[0]);
      read_and_check(`AFU_LB_PID, 4, 64'(lb_writes));
      read_and_check(2, 1, scratch_model[2]);
      end_test();
   endtask

   task automatic held_handshake();
      logic [`AFU_DATA_W-1:0] d;
      logic [`AFU_DATA_W-1:0] r;
      afu_status_e            st;
      begin_test("held_handshake");
      d = next_rand();
      do_req(3, 1, 1, d, 6, r, st);
      check_status("held write", RSP_OK, st);
      check_data("held write", '0, r);
      scratch_model[3] = d;
      do_req(3, 0, 1, '0, 5, r, st);
      check_status("held read", RSP_OK, st);
      check_data("held read", scratch_model[3], r);
      end_test();
   endtask

   initial begin
      i_arst_n    <= 1'b0;
      i_req       <= 1'b0;
      i_req_pid   <= '0;
      i_req_op    <= '0;
      i_req_addr  <= '0;
      i_req_wdata <= '0;
      repeat (RESET_CYCLES) @(posedge i_clk);
      i_arst_n <= 1'b1;
      @(negedge i_clk);
      begin_test("reset_state");
      if (o_ack !== 1'b0) begin
         errors++;
         $display("%s: o_ack is not low after reset", test_name);
      end
      end_test();
      read_headers();
      scratch_rw();
      loopback_rw();
      illegal_requests();
      held_handshake();
      $display("Summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule
